//--- vlog.f
+incdir+include
source/ob_pkg.sv
source/ob_insert_locate.sv
source/ob_cancel_match.sv
source/ob_entry_store.sv
source/ob_table.sv
testbench/tb_ob_table.sv

//--- Makefile
# Verilator build and run for the order book table

VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_ob_table
FLIST     = vlog.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- testbench/tb_ob_table.sv
// Order book table testbench
// Ask side, directed and random operations

`timescale 1ns/1ps
`include "ob_settings.svh"

module tb_ob_table
  import ob_pkg::*;
();

  localparam int depth = `OB_DEPTH;
  // Clock steps over reset and all tests
  localparam int sched_ops   = 115;
  localparam int cycle_limit = 20 * sched_ops;

  localparam int op_none = 0;
  localparam int op_ins  = 1;
  localparam int op_can  = 2;
  localparam int op_hpop = 3;
  localparam int op_rpop = 4;

  // Ask side marks a free slot with the top price
  localparam price_t no_price = '1;
  localparam entry_t blank    = '{uid: '0, price: '1, qty: '0};

  typedef entry_t [depth:0] table_t;

  logic   clk;
  logic   rst;
  logic   insert;
  entry_t insert_entry;
  logic   cancel;
  uid_t   cancel_uid;
  logic   head_pop;
  logic   reject_pop;
  logic   head_vld;
  entry_t head_entry;
  logic   head_did_update;
  logic   reject_vld;
  entry_t reject_entry;
  logic   cancel_hit;
  entry_t cancel_hit_entry;

  // Model state
  // cur_tbl is what the DUT shows in this cycle
  table_t      cur_tbl;
  table_t      pend_tbl;
  logic        cur_upd;
  logic        pend_upd;
  logic        exp_hit;
  entry_t      exp_hit_entry;
  logic        checking;
  logic [31:0] lfsr;
  bit          used_uid [256];
  int          err_count;
  int          test_errs;
  int          n_tests;
  int          n_failed;
  int          cycles;

  ob_table #(
    .is_ask           (1'b1)
  ) dut (
    .clk              (clk),
    .rst              (rst),
    .insert           (insert),
    .insert_entry     (insert_entry),
    .cancel           (cancel),
    .cancel_uid       (cancel_uid),
    .head_pop         (head_pop),
    .reject_pop       (reject_pop),
    .head_vld         (head_vld),
    .head_entry       (head_entry),
    .head_did_update  (head_did_update),
    .reject_vld       (reject_vld),
    .reject_entry     (reject_entry),
    .cancel_hit       (cancel_hit),
    .cancel_hit_entry (cancel_hit_entry)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // 32-bit Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Uids are never reused
  function automatic uid_t new_uid();
    uid_t u;
    u = uid_t'(rand_bits(8));
    while (used_uid[u]) begin
      u = uid_t'(rand_bits(8));
    end
    used_uid[u] = 1'b1;
    return u;
  endfunction

  function automatic uid_t absent_uid();
    for (int i = 255; i >= 0; i--) begin
      if (!used_uid[i]) begin
        return uid_t'(i);
      end
    end
    return '0;
  endfunction

  // Drop slot k and pull the lower slots up one place
  // Slot 0 keeps uid and qty with a free price
  function automatic table_t close_gap(input table_t t, input int k);
    table_t n;
    n = t;
    for (int i = k; i > 0; i--) begin
      n[i] = t[i-1];
    end
    n[0].price = no_price;
    return n;
  endfunction

  // Expected table after one operation
  function automatic table_t apply_op(
    input  table_t t,
    input  int     op,
    input  entry_t e,
    input  uid_t   cu,
    output logic   hit,
    output entry_t hit_entry,
    output logic   upd
  );
    table_t n;
    int     pos;
    n         = t;
    hit       = 1'b0;
    hit_entry = '0;
    upd       = 1'b0;
    pos       = -1;
    if (op == op_ins) begin
      // Highest slot that is free or strictly worse
      // Equal price stays ahead of the new order
      for (int i = 0; i <= depth; i++) begin
        if (t[i].price == no_price || e.price < t[i].price) begin
          pos = i;
        end
      end
      if (pos >= 0) begin
        for (int i = 0; i < pos; i++) begin
          n[i] = t[i+1];
        end
        n[pos] = e;
      end
      upd = (pos == depth);
    end else if (op == op_can) begin
      for (int i = 0; i <= depth; i++) begin
        if (t[i].price != no_price && t[i].uid == cu) begin
          pos = i;
        end
      end
      if (pos >= 0) begin
        hit       = 1'b1;
        hit_entry = t[pos];
        n         = close_gap(t, pos);
      end
      upd = (pos == depth);
    end else if (op == op_hpop) begin
      n   = close_gap(t, depth);
      upd = 1'b1;
    end else if (op == op_rpop) begin
      n[0].price = no_price;
    end
    return n;
  endfunction

  task automatic check_entry(input string what, input entry_t got, input entry_t exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
      err_count++;
      test_errs++;
    end
  endtask

  // Mid-cycle compare against the model
  always @(negedge clk) begin
    if (checking) begin
      check_entry("head_entry", head_entry, cur_tbl[depth]);
      check_flag("head_vld", head_vld, cur_tbl[depth].price != no_price);
      check_entry("reject_entry", reject_entry, cur_tbl[0]);
      check_flag("reject_vld", reject_vld, cur_tbl[0].price != no_price);
      check_flag("head_did_update", head_did_update, cur_upd);
      check_flag("cancel_hit", cancel_hit, exp_hit);
      check_entry("cancel_hit_entry", cancel_hit_entry, exp_hit_entry);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  // One clock of stimulus driven just after the edge
  task automatic step(input int op, input entry_t e, input uid_t cu);
    @(posedge clk);
    #1;
    cur_tbl      = pend_tbl;
    cur_upd      = pend_upd;
    insert       = (op == op_ins);
    insert_entry = e;
    cancel       = (op == op_can);
    cancel_uid   = cu;
    head_pop     = (op == op_hpop);
    reject_pop   = (op == op_rpop);
    pend_tbl     = apply_op(cur_tbl, op, e, cu, exp_hit, exp_hit_entry, pend_upd);
  endtask

  task automatic idle();
    step(op_none, blank, '0);
  endtask

  task automatic add_order(input price_t p, output entry_t e);
    e.uid   = new_uid();
    e.price = p;
    e.qty   = qty_t'(rand_bits(12));
    step(op_ins, e, '0);
  endtask

  // Enough pops to empty a full table and its reject slot
  task automatic clear_table();
    for (int i = 0; i <= depth; i++) begin
      step(op_hpop, blank, '0);
    end
    step(op_rpop, blank, '0);
    idle();
  endtask

  // Nine orders with distinct prices
  // The worst lands in the reject slot
  task automatic fill_table(output entry_t best, output entry_t second, output entry_t worst);
    entry_t      e;
    logic [31:0] r;
    clear_table();
    best   = blank;
    second = blank;
    worst  = '0;
    for (int i = 0; i <= depth; i++) begin
      r = rand_bits(12);
      add_order({r[11:0], 4'(i)}, e);
      if (e.price < best.price) begin
        second = best;
        best   = e;
      end else if (e.price < second.price) begin
        second = e;
      end
      if (e.price > worst.price) begin
        worst = e;
      end
    end
    idle();
  endtask

  task automatic finish_test(input string name);
    n_tests++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", n_tests, name);
    end else begin
      n_failed++;
      $display("test %0d %s: %0d errors", n_tests, name, test_errs);
    end
    test_errs = 0;
  endtask

  initial begin
    entry_t      e;
    entry_t      best;
    entry_t      second;
    entry_t      worst;
    entry_t      keep_head;
    entry_t      keep_rej;
    entry_t      order_q [$];
    logic [31:0] r;
    price_t      p;
    uid_t        u;
    int          k;
    lfsr         = 32'd78706;
    rst          = 1'b1;
    insert       = 1'b0;
    insert_entry = '0;
    cancel       = 1'b0;
    cancel_uid   = '0;
    head_pop     = 1'b0;
    reject_pop   = 1'b0;
    checking     = 1'b0;
    err_count    = 0;
    test_errs    = 0;
    n_tests      = 0;
    n_failed     = 0;
    cycles       = 0;
    for (int i = 0; i <= depth; i++) begin
      cur_tbl[i] = blank;
    end
    pend_tbl      = cur_tbl;
    cur_upd       = 1'b0;
    pend_upd      = 1'b0;
    exp_hit       = 1'b0;
    exp_hit_entry = '0;
    repeat (4) @(posedge clk);
    #1;
    rst      = 1'b0;
    checking = 1'b1;

    // Empty after reset and then best price at the head
    check_flag("head_vld after reset", head_vld, 1'b0);
    check_flag("reject_vld after reset", reject_vld, 1'b0);
    check_flag("head_did_update after reset", head_did_update, 1'b0);
    best = blank;
    for (int i = 0; i < 6; i++) begin
      p = price_t'(rand_bits(16));
      if (p == no_price) begin
        p = 16'hfffe;
      end
      add_order(p, e);
      if (e.price < best.price) begin
        best = e;
      end
    end
    idle();
    check_entry("head after random inserts", head_entry, best);
    finish_test("reset and sorted inserts");

    // Same price comes out in arrival order
    clear_table();
    p = price_t'(rand_bits(15));
    for (int i = 0; i < 4; i++) begin
      add_order(p, e);
      order_q.push_back(e);
    end
    idle();
    for (int i = 0; i < 4; i++) begin
      check_entry("head in arrival order", head_entry, order_q[i]);
      step(op_hpop, blank, '0);
      idle();
    end
    finish_test("equal price order");

    // Overflow into the reject slot
    fill_table(best, second, worst);
    check_flag("reject_vld on full table", reject_vld, 1'b1);
    check_entry("reject_entry on full table", reject_entry, worst);
    add_order(16'hfffe, e);
    idle();
    check_entry("reject_entry after worse insert", reject_entry, worst);
    check_entry("head after worse insert", head_entry, best);
    step(op_rpop, blank, '0);
    idle();
    check_flag("reject_vld after reject_pop", reject_vld, 1'b0);
    finish_test("reject slot");

    // Cancel hit and miss followed by a random mix
    step(op_can, blank, second.uid);
    @(negedge clk);
    check_flag("cancel_hit on present uid", cancel_hit, 1'b1);
    check_entry("cancel_hit_entry on present uid", cancel_hit_entry, second);
    idle();
    check_entry("head after cancel", head_entry, best);
    keep_head = cur_tbl[depth];
    keep_rej  = cur_tbl[0];
    u         = absent_uid();
    step(op_can, blank, u);
    @(negedge clk);
    check_flag("cancel_hit on absent uid", cancel_hit, 1'b0);
    check_entry("cancel_hit_entry on absent uid", cancel_hit_entry, '0);
    idle();
    check_entry("head after cancel miss", head_entry, keep_head);
    check_entry("reject after cancel miss", reject_entry, keep_rej);
    for (int i = 0; i < 24; i++) begin
      r = rand_bits(3);
      if (r < 4) begin
        p = price_t'(rand_bits(16));
        if (p == no_price) begin
          p = 16'h0000;
        end
        add_order(p, e);
      end else if (r < 6) begin
        // Stale uids from free slots give misses
        k = int'(rand_bits(3)) + 1;
        step(op_can, blank, pend_tbl[k].uid);
      end else if (r == 6) begin
        step(op_hpop, blank, '0);
      end else begin
        step(op_rpop, blank, '0);
      end
    end
    idle();
    finish_test("cancel and random mix");

    // Head pop promotes and pulls the reject entry back
    fill_table(best, second, worst);
    step(op_hpop, blank, '0);
    idle();
    check_flag("head_did_update after head_pop", head_did_update, 1'b1);
    check_entry("head after head_pop", head_entry, second);
    check_flag("reject_vld after head_pop", reject_vld, 1'b0);
    idle();
    check_flag("head_did_update one cycle only", head_did_update, 1'b0);
    add_order(16'hfffe, e);
    idle();
    check_flag("head_did_update on insert below head", head_did_update, 1'b0);
    check_entry("head after insert below head", head_entry, second);
    finish_test("head pop and update pulse");

    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, err_count);
    if (n_failed == 0 && err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

//--- source/ob_table.sv
// Order book table, one side
// Top level wiring

`timescale 1ns/1ps
`include "ob_settings.svh"

module ob_table
  import ob_pkg::*;
#(
  // 1 for the ask side, 0 for the bid side
  parameter bit is_ask = 1'b1
) (
  input  logic    clk,
  input  logic    rst,

  // Insert a new order by price
  input  logic    insert,
  input  entry_t  insert_entry,

  // Cancel by uid
  input  logic    cancel,
  input  uid_t    cancel_uid,

  // Pops
  input  logic    head_pop,
  input  logic    reject_pop,

  // Best order
  output logic    head_vld,
  output entry_t  head_entry,
  output logic    head_did_update,

  // Order pushed off a full table
  output logic    reject_vld,
  output entry_t  reject_entry,

  // Same-cycle cancel result
  output logic    cancel_hit,
  output entry_t  cancel_hit_entry
);

  entry_t [`OB_DEPTH:0] slots;
  slot_vec_t            slot_vld;
  slot_vec_t            install_sel;
  slot_vec_t            shift_dn;
  slot_vec_t            cancel_shift_up;

  // Where an insert lands
  ob_insert_locate #(
    .is_ask       (is_ask)
  ) u_insert_locate (
    .insert       (insert),
    .insert_price (insert_entry.price),
    .slots        (slots),
    .install_sel  (install_sel),
    .shift_dn     (shift_dn)
  );

  // Which slot a cancel removes
  ob_cancel_match u_cancel_match (
    .cancel           (cancel),
    .cancel_uid       (cancel_uid),
    .slots            (slots),
    .slot_vld         (slot_vld),
    .cancel_hit       (cancel_hit),
    .cancel_hit_entry (cancel_hit_entry),
    .cancel_shift_up  (cancel_shift_up)
  );

  // Slot state
  ob_entry_store #(
    .is_ask          (is_ask)
  ) u_entry_store (
    .clk             (clk),
    .rst             (rst),
    .insert_entry    (insert_entry),
    .install_sel     (install_sel),
    .shift_dn        (shift_dn),
    .cancel_shift_up (cancel_shift_up),
    .head_pop        (head_pop),
    .reject_pop      (reject_pop),
    .slots           (slots),
    .slot_vld        (slot_vld),
    .head_did_update (head_did_update)
  );

  // Head and reject read the end slots directly
  assign head_entry   = slots[`OB_DEPTH];
  assign head_vld     = slot_vld[`OB_DEPTH];
  assign reject_entry = slots[0];
  assign reject_vld   = slot_vld[0];

endmodule

//--- source/ob_entry_store.sv
// Order book slot registers
// Per-slot next state, valid flags, head pulse

`timescale 1ns/1ps
`include "ob_settings.svh"

module ob_entry_store
  import ob_pkg::*;
#(
  parameter bit is_ask = 1'b1
) (
  input  logic                  clk,
  input  logic                  rst,
  input  entry_t                insert_entry,
  input  slot_vec_t             install_sel,
  input  slot_vec_t             shift_dn,
  input  slot_vec_t             cancel_shift_up,
  input  logic                  head_pop,
  input  logic                  reject_pop,
  output entry_t [`OB_DEPTH:0]  slots,
  output slot_vec_t             slot_vld,
  output logic                  head_did_update
);

  localparam int depth = `OB_DEPTH;

  // Content of a free slot
  localparam entry_t empty_entry = '{
    uid:   '0,
    price: empty_price(is_ask),
    qty:   '0
  };

  entry_t [depth:0] slot_nxt;
  slot_vec_t        slot_we;
  slot_vec_t        shift_up;

  // Head pop shifts the whole table up
  // Cancel shifts from the hit slot down
  assign shift_up = cancel_shift_up | {(depth + 1){head_pop}};

  always_comb begin : next_proc
    slot_nxt = slots;
    slot_we  = '0;

    // Head slot
    // Nothing sits above it, so no shift down case
    slot_we[depth] = install_sel[depth] | shift_up[depth];
    unique casez ({install_sel[depth], shift_up[depth]})
      2'b1?: begin
        // New best order
        slot_nxt[depth] = insert_entry;
      end
      2'b01: begin
        // Next best becomes head
        slot_nxt[depth] = slots[depth-1];
      end
      default: begin
        slot_nxt[depth] = slots[depth];
      end
    endcase

    // Body slots
    for (int i = depth - 1; i > 0; i--) begin
      slot_we[i] = install_sel[i] | shift_up[i] | shift_dn[i];
      unique casez ({install_sel[i], shift_up[i], shift_dn[i]})
        3'b1??: begin
          slot_nxt[i] = insert_entry;
        end
        3'b01?: begin
          // Pull up the entry below
          slot_nxt[i] = slots[i-1];
        end
        3'b001: begin
          // Push down, take the entry above
          slot_nxt[i] = slots[i+1];
        end
        default: begin
          slot_nxt[i] = slots[i];
        end
      endcase
    end

    // Reject slot
    slot_we[0] = install_sel[0] | shift_up[0] | shift_dn[0] | reject_pop;
    unique casez ({install_sel[0], shift_up[0], shift_dn[0], reject_pop})
      4'b1???: begin
        // Order only beats the old reject entry
        slot_nxt[0] = insert_entry;
      end
      4'b01??: begin
        // Entry moved up into slot 1, mark this one free
        slot_nxt[0]       = slots[0];
        slot_nxt[0].price = empty_price(is_ask);
      end
      4'b001?: begin
        // Worst body entry falls off the table
        slot_nxt[0] = slots[1];
      end
      4'b0001: begin
        slot_nxt[0]       = slots[0];
        slot_nxt[0].price = empty_price(is_ask);
      end
      default: begin
        slot_nxt[0] = slots[0];
      end
    endcase
  end

  // A slot holds an order whenever its price is not the empty marker
  always_comb begin : vld_proc
    for (int i = 0; i <= depth; i++) begin
      slot_vld[i] = slots[i].price != empty_price(is_ask);
    end
  end

  // Slot registers, written only when enabled
  // Head pulse follows any write to the head slot
  always_ff @(posedge clk) begin : slot_reg
    if (rst) begin
      for (int i = 0; i <= depth; i++) begin
        slots[i] <= empty_entry;
      end
      head_did_update <= 1'b0;
    end else begin
      for (int i = 0; i <= depth; i++) begin
        if (slot_we[i]) begin
          slots[i] <= slot_nxt[i];
        end
      end
      head_did_update <= slot_we[depth];
    end
  end

endmodule

//--- source/ob_cancel_match.sv
// Cancel uid match
// Hit report and shift-up mask

`timescale 1ns/1ps
`include "ob_settings.svh"

module ob_cancel_match
  import ob_pkg::*;
(
  input  logic                  cancel,
  input  uid_t                  cancel_uid,
  input  entry_t [`OB_DEPTH:0]  slots,
  input  slot_vec_t             slot_vld,
  output logic                  cancel_hit,
  output entry_t                cancel_hit_entry,
  output slot_vec_t             cancel_shift_up
);

  // One-hot uid match over valid slots
  // Uids are unique, so at most one bit is set
  slot_vec_t uid_match;

  always_comb begin : match_proc
    for (int i = 0; i <= `OB_DEPTH; i++) begin
      uid_match[i] = cancel & slot_vld[i] & (slots[i].uid == cancel_uid);
    end
  end

  // Hit flag straight out, same cycle as the strobe
  assign cancel_hit = |uid_match;

  // OR-mux of the matching entry
  // Nothing selected reads as zero on a miss
  always_comb begin : mux_proc
    cancel_hit_entry = '0;
    for (int i = 0; i <= `OB_DEPTH; i++) begin
      if (uid_match[i]) begin
        cancel_hit_entry = cancel_hit_entry | slots[i];
      end
    end
  end

  // Hit slot and all slots below it shift up by one
  // Closes the gap left by the cancelled order
  always_comb begin : mask_proc
    logic seen;
    seen = 1'b0;
    for (int i = `OB_DEPTH; i >= 0; i--) begin
      seen               = seen | uid_match[i];
      cancel_shift_up[i] = seen;
    end
  end

  // Reject slot is covered by the mask on any hit
  // so a valid reject entry returns to the bottom body slot

endmodule

//--- source/ob_insert_locate.sv
// Insert slot locator
// Picks install slot and shift-down mask

`timescale 1ns/1ps
`include "ob_settings.svh"

module ob_insert_locate
  import ob_pkg::*;
#(
  parameter bit is_ask = 1'b1
) (
  input  logic                  insert,
  input  price_t                insert_price,
  input  entry_t [`OB_DEPTH:0]  slots,
  output slot_vec_t             install_sel,
  output slot_vec_t             shift_dn
);

  // Slots the new price would displace
  slot_vec_t match;

  always_comb begin : match_proc
    for (int i = 0; i <= `OB_DEPTH; i++) begin
      // Strictly better price wins the slot
      // An empty slot always takes the new order
      match[i] = insert &
                 (better_price(is_ask, insert_price, slots[i].price) |
                  (slots[i].price == empty_price(is_ask)));
    end
  end

  // Table is sorted, so matches form a run from slot 0 upward
  // Install goes to the top of that run
  // This priority pick is the critical path of the table
  always_comb begin : pick_proc
    install_sel = '0;
    for (int i = 0; i <= `OB_DEPTH; i++) begin
      // Later (higher) hits override earlier ones
      if (match[i]) begin
        install_sel = slot_vec_t'(1) << i;
      end
    end
  end

  // Everything strictly below the install slot moves down one place
  // Slot 1 falls into the reject slot when the table is full
  always_comb begin : shift_proc
    logic above;
    above = 1'b0;
    for (int i = `OB_DEPTH; i >= 0; i--) begin
      shift_dn[i] = above;
      above       = above | install_sel[i];
    end
  end

  // No match at all means the insert is dropped
  // That happens when a valid reject entry beats the new price

endmodule

//--- source/ob_pkg.sv
// Order book types and price helpers

`include "ob_settings.svh"

package ob_pkg;

  // Field types
  typedef logic [`OB_PRICE_W-1:0] price_t;
  typedef logic [`OB_UID_W-1:0]   uid_t;
  typedef logic [`OB_QTY_W-1:0]   qty_t;

  // One resting order
  // Uid sits in the top bits, quantity at the bottom
  typedef struct packed {
    uid_t   uid;
    price_t price;
    qty_t   qty;
  } entry_t;

  // One bit per slot, head at the MSB, reject slot at bit 0
  typedef logic [`OB_DEPTH:0] slot_vec_t;

  // Price that marks a slot as empty
  // Ask side uses the top price so an empty slot sorts last
  function automatic price_t empty_price(input bit is_ask);
    return is_ask ? '1 : '0;
  endfunction

  // True when price a strictly beats price b on the given side
  // Equal prices never beat each other, keeps arrival order
  function automatic logic better_price(
    input bit     is_ask,
    input price_t a,
    input price_t b
  );
    if (is_ask) begin
      return a < b;
    end else begin
      return a > b;
    end
  endfunction

endpackage

//--- include/ob_settings.svh
// Order book table settings
// Depth and field widths

`ifndef OB_SETTINGS_SVH
`define OB_SETTINGS_SVH

// Number of table slots above the reject slot
// Slot OB_DEPTH is the head, slot 0 is the reject slot
`define OB_DEPTH 8

// Price field width, plain unsigned binary
`define OB_PRICE_W 16

// Order identifier width
// Uids are expected to be unique across resting orders
`define OB_UID_W 8

// Order quantity width
`define OB_QTY_W 12

// Entry width follows from the three fields
// uid + price + quantity = 36 bits with the defaults above

// Changing OB_DEPTH changes the slot vector width too
// Widths only affect the package types, not the table logic

`endif
